// ==== datapath.f ====
+incdir+logic
logic/datapath_pkg.sv
logic/issue_stage.sv
logic/operand_bank.sv
logic/alu.sv
logic/datapath.sv
test/datapath_tb.sv

// ==== logic/alu.sv ====
`default_nettype none

`include "datapath_defines.svh"

module alu import datapath_pkg::*; (
    input  wire logic                     clock,
    input  wire logic                     arst_n,
    input  wire logic [`OPCODE_WIDTH-1:0] op,
    input  wire d_operand_u               d,
    input  wire logic [`WORD_WIDTH-1:0]   a,
    input  wire logic [`WORD_WIDTH-1:0]   b,

    output logic [`WORD_WIDTH-1:0]        result,
    output logic                          c_out,
    output d_operand_u                    d_out
);

    logic [`WORD_WIDTH:0]   sum;
    logic [`WORD_WIDTH:0]   diff;
    logic [`WORD_WIDTH-1:0] mul_lo;
    logic [`WORD_WIDTH-1:0] result_next;
    logic                   carry_next;

    // One extra bit holds the carry of the add and the borrow of the subtract
    assign sum    = {1'b0, a} + {1'b0, b};
    assign diff   = {1'b0, a} - {1'b0, b};
    assign mul_lo = a * b;

    // --------------------------------------------------------------------------
    // Operation select
    // --------------------------------------------------------------------------

    always_comb begin
        result_next = '0;
        carry_next  = 1'b0;
        case (op)
            `OP_ADD: begin
                result_next = sum[`WORD_WIDTH-1:0];
                carry_next  = sum[`WORD_WIDTH];
            end
            `OP_SUB: begin
                result_next = diff[`WORD_WIDTH-1:0];
                carry_next  = diff[`WORD_WIDTH];
            end
            `OP_AND:    result_next = a & b;
            `OP_OR:     result_next = a | b;
            `OP_XOR:    result_next = a ^ b;
            `OP_PASS_A: result_next = a;
            `OP_MUL_LO: result_next = mul_lo;
            // NOP and the unused codes leave zeros
            default: begin
            end
        endcase
    end

    // --------------------------------------------------------------------------
    // Output register, D travels with the result it addresses
    // --------------------------------------------------------------------------

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
            c_out  <= 1'b0;
            d_out  <= '0;
        end else begin
            result <= result_next;
            c_out  <= carry_next;
            d_out  <= d;
        end
    end

endmodule

`default_nettype wire

// ==== logic/datapath.sv ====
`default_nettype none

`include "datapath_defines.svh"

module datapath import datapath_pkg::*; (
    input  wire logic                     clock,
    input  wire logic                     arst_n,

    input  wire logic [`INSTR_WIDTH-1:0]  instr,

    input  wire logic [`WORD_WIDTH-1:0]   a_io_in,
    input  wire logic [`WORD_WIDTH-1:0]   b_io_in,
    input  wire logic                     a_io_in_ef,
    input  wire logic                     b_io_in_ef,
    input  wire logic                     a_io_out_ef,
    input  wire logic                     b_io_out_ef,

    output logic                          io_ready,
    output logic                          a_io_rden,
    output logic                          b_io_rden,
    output logic                          a_io_wren,
    output logic                          b_io_wren,
    output logic [`WORD_WIDTH-1:0]        a_io_out,
    output logic [`WORD_WIDTH-1:0]        b_io_out,

    output logic [`WORD_WIDTH-1:0]        alu_result,
    output logic                          alu_c_out,
    output d_operand_u                    alu_d_out
);

    logic [`ADDR_WIDTH-1:0]   a_read_addr;
    logic [`ADDR_WIDTH-1:0]   b_read_addr;
    logic                     a_read_is_io;
    logic                     b_read_is_io;
    logic [`OPCODE_WIDTH-1:0] op;
    d_operand_u               d;
    logic                     a_wren;
    logic                     b_wren;
    logic                     a_write_is_io;
    logic                     b_write_is_io;
    logic [`WORD_WIDTH-1:0]   a_read_data;
    logic [`WORD_WIDTH-1:0]   b_read_data;

    // --------------------------------------------------------------------------
    // Issue: decode, I/O readiness, annul, write control delay
    // --------------------------------------------------------------------------

    issue_stage u_issue_stage (
        .clock          (clock),
        .arst_n         (arst_n),
        .instr          (instr),
        .a_io_in_ef     (a_io_in_ef),
        .b_io_in_ef     (b_io_in_ef),
        .a_io_out_ef    (a_io_out_ef),
        .b_io_out_ef    (b_io_out_ef),
        .io_ready       (io_ready),
        .a_io_rden      (a_io_rden),
        .b_io_rden      (b_io_rden),
        .a_read_addr    (a_read_addr),
        .b_read_addr    (b_read_addr),
        .a_read_is_io   (a_read_is_io),
        .b_read_is_io   (b_read_is_io),
        .op             (op),
        .d              (d),
        .a_wren         (a_wren),
        .b_wren         (b_wren),
        .a_write_is_io  (a_write_is_io),
        .b_write_is_io  (b_write_is_io)
    );

    // --------------------------------------------------------------------------
    // Operand banks, written back from the ALU output two cycles after issue
    // --------------------------------------------------------------------------

    operand_bank #(
        .BANK_SEL       (0)
    ) u_bank_a (
        .clock          (clock),
        .arst_n         (arst_n),
        .read_addr      (a_read_addr),
        .read_is_io     (a_read_is_io),
        .io_in          (a_io_in),
        .wren           (a_wren),
        .write_is_io    (a_write_is_io),
        .write_index    (alu_d_out.fields.index),
        .write_data     (alu_result),
        .read_data      (a_read_data),
        .io_wren        (a_io_wren),
        .io_out         (a_io_out)
    );

    operand_bank #(
        .BANK_SEL       (1)
    ) u_bank_b (
        .clock          (clock),
        .arst_n         (arst_n),
        .read_addr      (b_read_addr),
        .read_is_io     (b_read_is_io),
        .io_in          (b_io_in),
        .wren           (b_wren),
        .write_is_io    (b_write_is_io),
        .write_index    (alu_d_out.fields.index),
        .write_data     (alu_result),
        .read_data      (b_read_data),
        .io_wren        (b_io_wren),
        .io_out         (b_io_out)
    );

    alu u_alu (
        .clock          (clock),
        .arst_n         (arst_n),
        .op             (op),
        .d              (d),
        .a              (a_read_data),
        .b              (b_read_data),
        .result         (alu_result),
        .c_out          (alu_c_out),
        .d_out          (alu_d_out)
    );

endmodule

`default_nettype wire

// ==== logic/datapath_defines.svh ====
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// Data and instruction widths
`define WORD_WIDTH      16
`define INSTR_WIDTH     26
`define OPCODE_WIDTH    4
`define D_WIDTH         8
`define ADDR_WIDTH      7

// Each bank holds BANK_DEPTH words and maps its top index to the I/O port
`define BANK_DEPTH      128
`define IO_INDEX        7'd127

// --------------------------------------------------------------------------
// Opcodes, values 8 to 15 decode as NOP
// --------------------------------------------------------------------------

`define OP_NOP          4'd0
`define OP_ADD          4'd1
`define OP_SUB          4'd2
`define OP_AND          4'd3
`define OP_OR           4'd4
`define OP_XOR          4'd5
`define OP_PASS_A       4'd6
`define OP_MUL_LO       4'd7

`endif

// ==== logic/datapath_pkg.sv ====
`default_nettype none

`include "datapath_defines.svh"

package datapath_pkg;

    // The D operand is one address with two readings: a flat 8-bit value,
    // or a bank select bit above the index inside that bank
    typedef union packed {
        logic [`D_WIDTH-1:0] raw;
        struct packed {
            logic                   bank;
            logic [`ADDR_WIDTH-1:0] index;
        } fields;
    } d_operand_u;

endpackage

`default_nettype wire

// ==== logic/issue_stage.sv ====
`default_nettype none

`include "datapath_defines.svh"

module issue_stage import datapath_pkg::*; (
    input  wire logic                     clock,
    input  wire logic                     arst_n,
    input  wire logic [`INSTR_WIDTH-1:0]  instr,
    input  wire logic                     a_io_in_ef,
    input  wire logic                     b_io_in_ef,
    input  wire logic                     a_io_out_ef,
    input  wire logic                     b_io_out_ef,

    output logic                          io_ready,
    output logic                          a_io_rden,
    output logic                          b_io_rden,
    output logic [`ADDR_WIDTH-1:0]        a_read_addr,
    output logic [`ADDR_WIDTH-1:0]        b_read_addr,
    output logic                          a_read_is_io,
    output logic                          b_read_is_io,
    output logic [`OPCODE_WIDTH-1:0]      op,
    output d_operand_u                    d,
    output logic                          a_wren,
    output logic                          b_wren,
    output logic                          a_write_is_io,
    output logic                          b_write_is_io
);

    // Field positions, from the least significant end: B, A, D, opcode
    localparam int A_LSB  = `ADDR_WIDTH;
    localparam int D_LSB  = 2 * `ADDR_WIDTH;
    localparam int OP_LSB = D_LSB + `D_WIDTH;

    logic [`OPCODE_WIDTH-1:0] op_raw;
    d_operand_u               d_raw;
    logic [`ADDR_WIDTH-1:0]   a_raw;
    logic [`ADDR_WIDTH-1:0]   b_raw;
    logic                     out_room;
    logic                     stall_cond;

    logic [`OPCODE_WIDTH-1:0] op_k;
    d_operand_u               d_k;
    logic                     is_write;
    logic [1:0]               wren_s0;
    logic [1:0]               io_s0;
    logic [1:0]               wren_s1;
    logic [1:0]               io_s1;
    logic [1:0]               wren_s2;
    logic [1:0]               io_s2;

    assign op_raw    = instr[OP_LSB +: `OPCODE_WIDTH];
    assign d_raw.raw = instr[D_LSB +: `D_WIDTH];
    assign a_raw     = instr[A_LSB +: `ADDR_WIDTH];
    assign b_raw     = instr[0 +: `ADDR_WIDTH];

    // --------------------------------------------------------------------------
    // I/O readiness, any blocked port annuls the whole instruction
    // --------------------------------------------------------------------------

    assign out_room   = d_raw.fields.bank ? b_io_out_ef : a_io_out_ef;
    assign stall_cond = ((a_raw == `IO_INDEX) && !a_io_in_ef) ||
                        ((b_raw == `IO_INDEX) && !b_io_in_ef) ||
                        ((d_raw.fields.index == `IO_INDEX) && !out_room);
    assign io_ready   = !stall_cond;

    // An annulled instruction becomes all zeros
    assign op_k        = io_ready ? op_raw : `OP_NOP;
    assign d_k.raw     = io_ready ? d_raw.raw : '0;
    assign a_read_addr = io_ready ? a_raw : '0;
    assign b_read_addr = io_ready ? b_raw : '0;

    assign a_read_is_io = (a_read_addr == `IO_INDEX);
    assign b_read_is_io = (b_read_addr == `IO_INDEX);
    assign a_io_rden    = a_read_is_io;
    assign b_io_rden    = b_read_is_io;

    // Only opcodes 1 to 7 write back
    assign is_write   = (op_k != `OP_NOP) && (op_k <= `OP_MUL_LO);
    assign wren_s0[0] = is_write && !d_k.fields.bank;
    assign wren_s0[1] = is_write && d_k.fields.bank;
    assign io_s0      = wren_s0 & {2{d_k.fields.index == `IO_INDEX}};

    // --------------------------------------------------------------------------
    // Op and D go to the ALU, write control waits two cycles for the result
    // --------------------------------------------------------------------------

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            op      <= `OP_NOP;
            d       <= '0;
            wren_s1 <= '0;
            io_s1   <= '0;
            wren_s2 <= '0;
            io_s2   <= '0;
        end else begin
            op      <= op_k;
            d       <= d_k;
            wren_s1 <= wren_s0;
            io_s1   <= io_s0;
            wren_s2 <= wren_s1;
            io_s2   <= io_s1;
        end
    end

    assign a_wren        = wren_s2[0];
    assign b_wren        = wren_s2[1];
    assign a_write_is_io = io_s2[0];
    assign b_write_is_io = io_s2[1];

endmodule

`default_nettype wire

// ==== logic/operand_bank.sv ====
`default_nettype none

`include "datapath_defines.svh"

module operand_bank #(
    // 0 answers D bank A, 1 answers D bank B
    parameter int BANK_SEL = 0
) (
    input  wire logic                     clock,
    input  wire logic                     arst_n,

    // Read side, presented in the issue cycle
    input  wire logic [`ADDR_WIDTH-1:0]   read_addr,
    input  wire logic                     read_is_io,
    input  wire logic [`WORD_WIDTH-1:0]   io_in,

    // Write side, presented two cycles after issue
    input  wire logic                     wren,
    input  wire logic                     write_is_io,
    input  wire logic [`ADDR_WIDTH-1:0]   write_index,
    input  wire logic [`WORD_WIDTH-1:0]   write_data,

    output logic [`WORD_WIDTH-1:0]        read_data,
    output logic                          io_wren,
    output logic [`WORD_WIDTH-1:0]        io_out
);

    logic [`WORD_WIDTH-1:0] mem [`BANK_DEPTH];
    logic [`WORD_WIDTH-1:0] ram_q;
    logic [`WORD_WIDTH-1:0] io_q;
    logic                   read_is_io_q;
    logic                   ram_wren;

    // --------------------------------------------------------------------------
    // Memory with registered read
    // --------------------------------------------------------------------------

    // The I/O index never reaches the memory, so its word stays untouched
    assign ram_wren = wren && !write_is_io;

    // A read and a write to the same index on one edge return the old word
    always_ff @(posedge clock) begin
        ram_q <= mem[read_addr];
        if (ram_wren) begin
            mem[write_index] <= write_data;
        end
    end

    // --------------------------------------------------------------------------
    // Input port capture and read select
    // --------------------------------------------------------------------------

    // The port word is taken at the end of the cycle that raised rden
    always_ff @(posedge clock) begin
        if (read_is_io) begin
            io_q <= io_in;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            read_is_io_q <= 1'b0;
        end else begin
            read_is_io_q <= read_is_io;
        end
    end

    assign read_data = read_is_io_q ? io_q : ram_q;

    // --------------------------------------------------------------------------
    // Output port
    // --------------------------------------------------------------------------

    // wren comes from a reset register, so this pulse is low out of reset
    assign io_wren = wren && write_is_io;
    assign io_out  = write_data;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the datapath testbench with Verilator, then scan the log

cd "$(dirname "$0")" &&
verilator --binary --timescale 1ns/1ps --top-module datapath_tb \
    -f datapath.f -o datapath_sim > build.log 2>&1 &&
{ ./obj_dir/datapath_sim > sim.log 2>&1 || true; } &&
! grep -q "Result: FAILED" sim.log &&
grep -q "Result: PASSED" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== test/datapath_golden.txt ====
// instr a_io_in b_io_in flags(a_in b_in a_out b_out) io_ready rden(a b)
// result c_out d_out port_wren(a b) port_word, due 2 cycles later; all ones ends the table
1807fff 1234 5555 f 1 3 1234 0 01 0 0000
1a07f80 f00f 0000 f 1 2 f00f 0 81 0 0000
180bf80 8001 0000 f 1 2 8001 0 02 0 0000
1a0bf80 9000 0000 f 1 2 9000 0 82 0 0000
180ff80 0003 0000 f 1 2 0003 0 03 0 0000
1a0ff80 0005 0000 f 1 2 0005 0 83 0 0000
0410081 0000 0000 f 1 0 0243 1 04 0 0000
0814082 0000 0000 f 1 0 8234 1 05 0 0000
0c18101 0000 0000 f 1 0 8001 0 06 0 0000
101c102 0000 0000 f 1 0 9001 0 07 0 0000
1420081 0000 0000 f 1 0 e23b 0 08 0 0000
1c40183 0000 0000 f 1 0 000f 0 10 0 0000
0a14103 0000 0000 f 1 0 7ffc 0 85 0 0000
1804180 0000 0000 f 1 0 0003 0 01 0 0000
1828080 0000 0000 f 1 0 1234 0 0a 0 0000
182c080 0000 0000 f 1 0 1234 0 0b 0 0000
1830080 0000 0000 f 1 0 0003 0 0c 0 0000
05fc201 0000 0000 f 1 0 f252 0 7f 2 f252
17fc085 0000 0000 f 1 0 7fff 0 ff 1 7fff
1837f80 abcd 0000 7 0 0 0000 0 00 0 0000
1837f80 abcd 0000 f 1 2 abcd 0 0d 0 0000
05fc081 0000 0000 d 0 0 0000 0 00 0 0000
05fc081 0000 0000 f 1 0 f012 0 7f 2 f012
103817f 0000 0ff0 b 0 0 0000 0 00 0 0000
103817f 0000 0ff0 f 1 1 8ff1 0 0e 0 0000
183c680 0000 0000 f 1 0 abcd 0 0f 0 0000
0a18601 0000 0000 f 1 0 0ff4 1 86 0 0000
0c1c705 0000 0000 f 1 0 0ff0 0 07 0 0000
1c44102 0000 0000 f 1 0 9000 0 11 0 0000
2048081 0000 0000 f 1 0 0000 0 12 0 0000
ffffffff 0000 0000 0 0 0 0000 0 00 0 0000

// ==== test/datapath_tb.sv ====
`default_nettype none

`include "datapath_defines.svh"

module datapath_tb import datapath_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLOCK_PERIOD = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_LINES    = 64;
    localparam int NUM_COLS     = 11;
    localparam logic [31:0] END_MARK = 32'hffff_ffff;

    // Column offsets inside one golden line
    localparam int COL_INSTR  = 0;
    localparam int COL_A_IN   = 1;
    localparam int COL_B_IN   = 2;
    localparam int COL_FLAGS  = 3;
    localparam int COL_READY  = 4;
    localparam int COL_RDEN   = 5;
    localparam int COL_RESULT = 6;
    localparam int COL_CARRY  = 7;
    localparam int COL_D      = 8;
    localparam int COL_WREN   = 9;
    localparam int COL_PORT   = 10;

    logic                     clock;
    logic                     arst_n;
    logic [`INSTR_WIDTH-1:0]  instr;
    logic [`WORD_WIDTH-1:0]   a_io_in;
    logic [`WORD_WIDTH-1:0]   b_io_in;
    logic                     a_io_in_ef;
    logic                     b_io_in_ef;
    logic                     a_io_out_ef;
    logic                     b_io_out_ef;
    logic                     io_ready;
    logic                     a_io_rden;
    logic                     b_io_rden;
    logic                     a_io_wren;
    logic                     b_io_wren;
    logic [`WORD_WIDTH-1:0]   a_io_out;
    logic [`WORD_WIDTH-1:0]   b_io_out;
    logic [`WORD_WIDTH-1:0]   alu_result;
    logic                     alu_c_out;
    d_operand_u               alu_d_out;

    logic [31:0] golden [MAX_LINES * NUM_COLS];
    int          num_lines;
    int          timeout_limit;
    int          cycle_count;

    datapath u_datapath (
        .clock       (clock),
        .arst_n      (arst_n),
        .instr       (instr),
        .a_io_in     (a_io_in),
        .b_io_in     (b_io_in),
        .a_io_in_ef  (a_io_in_ef),
        .b_io_in_ef  (b_io_in_ef),
        .a_io_out_ef (a_io_out_ef),
        .b_io_out_ef (b_io_out_ef),
        .io_ready    (io_ready),
        .a_io_rden   (a_io_rden),
        .b_io_rden   (b_io_rden),
        .a_io_wren   (a_io_wren),
        .b_io_wren   (b_io_wren),
        .a_io_out    (a_io_out),
        .b_io_out    (b_io_out),
        .alu_result  (alu_result),
        .alu_c_out   (alu_c_out),
        .alu_d_out   (alu_d_out)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // --------------------------------------------------------------------------
    // Error handling and compare tasks
    // --------------------------------------------------------------------------

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [`WORD_WIDTH-1:0] expected,
                              input logic [`WORD_WIDTH-1:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch at %0d ns: %s expected %h, got %h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch at %0d ns: %s expected %b, got %b",
                               $time, name, expected, actual));
        end
    endtask

    task automatic check_d(input string name, input d_operand_u expected,
                           input d_operand_u actual);
        if (actual.raw !== expected.raw) begin
            fail_run($sformatf("mismatch at %0d ns: %s expected %h, got %h",
                               $time, name, expected.raw, actual.raw));
        end
    endtask

    // --------------------------------------------------------------------------
    // Stimulus and per-line checks
    // --------------------------------------------------------------------------

    task automatic apply_line(input int line);
        int base;
        base        = line * NUM_COLS;
        instr       = golden[base + COL_INSTR][`INSTR_WIDTH-1:0];
        a_io_in     = golden[base + COL_A_IN][`WORD_WIDTH-1:0];
        b_io_in     = golden[base + COL_B_IN][`WORD_WIDTH-1:0];
        a_io_in_ef  = golden[base + COL_FLAGS][3];
        b_io_in_ef  = golden[base + COL_FLAGS][2];
        a_io_out_ef = golden[base + COL_FLAGS][1];
        b_io_out_ef = golden[base + COL_FLAGS][0];
    endtask

    task automatic apply_idle();
        instr       = '0;
        a_io_in     = '0;
        b_io_in     = '0;
        a_io_in_ef  = 1'b0;
        b_io_in_ef  = 1'b0;
        a_io_out_ef = 1'b0;
        b_io_out_ef = 1'b0;
    endtask

    // Annul decision and read strobes belong to the issue cycle itself
    task automatic check_issue(input int line);
        int base;
        base = line * NUM_COLS;
        check_bit($sformatf("io_ready (line %0d)", line), golden[base + COL_READY][0], io_ready);
        check_bit($sformatf("a_io_rden (line %0d)", line), golden[base + COL_RDEN][1], a_io_rden);
        check_bit($sformatf("b_io_rden (line %0d)", line), golden[base + COL_RDEN][0], b_io_rden);
    endtask

    // Results of a line appear two cycles after its issue
    task automatic check_result(input int line);
        int base;
        base = line * NUM_COLS;
        check_word($sformatf("alu_result (line %0d)", line),
                   golden[base + COL_RESULT][`WORD_WIDTH-1:0], alu_result);
        check_bit($sformatf("alu_c_out (line %0d)", line), golden[base + COL_CARRY][0], alu_c_out);
        check_d($sformatf("alu_d_out (line %0d)", line),
                golden[base + COL_D][`D_WIDTH-1:0], alu_d_out);
        check_bit($sformatf("a_io_wren (line %0d)", line), golden[base + COL_WREN][1], a_io_wren);
        check_bit($sformatf("b_io_wren (line %0d)", line), golden[base + COL_WREN][0], b_io_wren);
        if (golden[base + COL_WREN][1]) begin
            check_word($sformatf("a_io_out (line %0d)", line),
                       golden[base + COL_PORT][`WORD_WIDTH-1:0], a_io_out);
        end
        if (golden[base + COL_WREN][0]) begin
            check_word($sformatf("b_io_out (line %0d)", line),
                       golden[base + COL_PORT][`WORD_WIDTH-1:0], b_io_out);
        end
    endtask

    // --------------------------------------------------------------------------
    // Main sequence
    // --------------------------------------------------------------------------

    initial begin
        int cycle;
        arst_n        = 1'b0;
        timeout_limit = 0;
        apply_idle();

        for (int i = 0; i < MAX_LINES * NUM_COLS; i++) begin
            golden[i] = END_MARK;
        end
        $readmemh("test/datapath_golden.txt", golden);
        num_lines = 0;
        while (num_lines < MAX_LINES && golden[num_lines * NUM_COLS] !== END_MARK) begin
            num_lines++;
        end
        if (num_lines == 0) begin
            fail_run("the golden file held no test lines");
        end
        timeout_limit = num_lines + RESET_CYCLES + 8;

        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        arst_n = 1'b1;

        // Nothing may strobe straight out of reset
        @(negedge clock);
        check_bit("a_io_rden after reset", 1'b0, a_io_rden);
        check_bit("b_io_rden after reset", 1'b0, b_io_rden);
        check_bit("a_io_wren after reset", 1'b0, a_io_wren);
        check_bit("b_io_wren after reset", 1'b0, b_io_wren);
        check_bit("alu_c_out after reset", 1'b0, alu_c_out);

        for (cycle = 0; cycle < num_lines + 2; cycle++) begin
            @(posedge clock);
            #DRIVE_DELAY;
            if (cycle < num_lines) begin
                apply_line(cycle);
            end else begin
                apply_idle();
            end
            @(negedge clock);
            if (cycle < num_lines) begin
                check_issue(cycle);
            end
            if (cycle >= 2) begin
                check_result(cycle - 2);
            end
        end

        $display("Result: PASSED");
        $finish;
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clock);
            cycle_count++;
            if (timeout_limit > 0 && cycle_count > timeout_limit) begin
                fail_run($sformatf("timeout: the run passed its limit of %0d cycles",
                                   timeout_limit));
            end
        end
    end

endmodule

`default_nettype wire
